/* aurora_tx_framer.f */
+incdir+src
src/aurora_tx_pkg.sv
src/link_qualifier.sv
src/session_scheduler.sv
src/packet_streamer.sv
src/aurora_tx_framer.sv
testbench/tb_aurora_tx_framer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the framer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
    --top-module tb_aurora_tx_framer -f aurora_tx_framer.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_aurora_tx_framer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

/* testbench/tb_aurora_tx_framer.sv */
`include "aurora_tx_defines.svh"

module tb_aurora_tx_framer;

    localparam aurora_tx_pkg::word_t EDS_BASE = 64'he000_0000_0000_0000;
    localparam aurora_tx_pkg::word_t ENC_BASE = 64'h5000_0000_0000_0000;
    // Packet kinds, slot 4 counts encode headers
    localparam int K_CTRL    = 1;
    localparam int K_EDS     = 2;
    localparam int K_ENC     = 3;
    localparam int K_ENC_HDR = 4;

    logic                      USER_CLK           = 1'b0;
    logic                      RESET              = 1'b1;
    logic                      CHANNEL_UP         = 1'b0;
    logic                      eds_frame_en_i     = 1'b0;
    logic                      pmt_start_en_i     = 1'b0;
    logic                      pcie_eds_end_i     = 1'b0;
    logic                      pcie_pmt_end_i     = 1'b0;
    logic                      eds_encode_empty_i = 1'b0;
    logic                      tx_tready_i        = 1'b0;
    aurora_tx_pkg::word_t      eds_data_i         = EDS_BASE;
    aurora_tx_pkg::word_t      encode_data_i      = ENC_BASE;
    aurora_tx_pkg::half_t      encoder_w_i        = 32'hc0de_0000;
    aurora_tx_pkg::half_t      encoder_x_i;
    // Fill levels held above the packet thresholds
    aurora_tx_pkg::eds_count_t eds_count_i        = 14'd600;
    aurora_tx_pkg::enc_count_t enc_count_i        = 12'd1100;
    logic                      eds_rd_o;
    logic                      eds_encode_rd_o;
    logic                      encode_rd_o;
    logic                      tx_tvalid_o;
    logic                      tx_tlast_o;
    aurora_tx_pkg::word_t      tx_tdata_o;
    aurora_tx_pkg::pack_cnt_t  eds_pack_cnt_o;
    aurora_tx_pkg::pack_cnt_t  encode_pack_cnt_o;

    int                   errors      = 0;
    int                   checks      = 0;
    int                   beat        = 0;
    int                   pkt         = 0;
    int                   up_run      = 0;
    int                   done [1:4]  = '{default: 0};
    bit                   eds_closing = 1'b0;
    bit                   enc_phase   = 1'b0;
    bit                   enc_stop    = 1'b0;
    bit                   timed_out   = 1'b0;
    aurora_tx_pkg::word_t exp_eds     = EDS_BASE;
    aurora_tx_pkg::word_t exp_enc     = ENC_BASE;
    aurora_tx_pkg::half_t exp_w       = 32'hc0de_0000;
    aurora_tx_pkg::word_t exp_word;

    aurora_tx_framer aurora_tx_framer_i (.*);

    //////////////////////////////////////////////////
    // Clock, sink and FIFO models
    //////////////////////////////////////////////////

    initial begin
        forever #20 USER_CLK = ~USER_CLK;
    end

    initial begin
        void'($urandom(32'h7aa9dec9));
        forever begin
            @(posedge USER_CLK);
            tx_tready_i <= ($urandom % 4) != 0;
        end
    end

    // FWFT FIFOs with ascending contents
    always @(posedge USER_CLK) begin
        if (eds_rd_o)
            eds_data_i <= eds_data_i + 64'd1;
        if (encode_rd_o)
            encode_data_i <= encode_data_i + 64'd1;
        if (eds_encode_rd_o)
            encoder_w_i <= encoder_w_i + 32'd1;
        // Cycles since the channel came up
        up_run <= (RESET || !CHANNEL_UP) ? 0 : up_run + 1;
    end

    assign encoder_x_i = ~encoder_w_i;

    assert property (@(posedge USER_CLK) disable iff (RESET) (up_run < 16) |-> !tx_tvalid_o)
        else report_mismatch("tvalid high before the channel was qualified");

    assert property (@(posedge USER_CLK) disable iff (RESET)
        (tx_tvalid_o && !tx_tready_i) |=>
            (tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tlast_o)))
        else report_mismatch("beat changed while tready was low");

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else report_mismatch(msg);
    endtask

    //////////////////////////////////////////////////
    // Scoreboard on accepted beats
    //////////////////////////////////////////////////

    always @(posedge USER_CLK) begin
        if (!RESET && tx_tvalid_o && tx_tready_i) begin
            if (beat == 0) begin
                case (tx_tdata_o)
                    `AURORA_HDR_CTRL: pkt = K_CTRL;
                    `AURORA_HDR_EDS:  pkt = K_EDS;
                    `AURORA_HDR_ENC:  pkt = K_ENC;
                    default:          pkt = 0;
                endcase
                // Run order is start, EDS data, end, then encode packets
                check(enc_phase ? (pkt == K_ENC && !enc_stop) :
                      (done[K_CTRL] == 0) ? (pkt == K_CTRL) :
                      (done[K_CTRL] == 1) && (pkt == K_EDS || (eds_closing && pkt == K_CTRL)),
                      $sformatf("header %h not expected here", tx_tdata_o));
                if (pkt == K_ENC)
                    done[K_ENC_HDR]++;
            end else begin
                case (pkt)
                    K_CTRL:  exp_word = (done[K_CTRL] == 0) ? `AURORA_CODE_EDS_START
                                                            : `AURORA_CODE_EDS_END;
                    K_EDS:   exp_word = (beat == 1) ? {exp_w, ~exp_w} : exp_eds;
                    default: exp_word = exp_enc;
                endcase
                check(tx_tdata_o == exp_word,
                      $sformatf("beat %0d is %h, expected %h", beat, tx_tdata_o, exp_word));
                if (pkt == K_EDS && beat == 1)
                    exp_w = exp_w + 32'd1;
                else if (pkt == K_EDS)
                    exp_eds = exp_eds + 64'd1;
                else if (pkt != K_CTRL)
                    exp_enc = exp_enc + 64'd1;
            end
            check(tx_tlast_o == (beat == ((pkt == K_CTRL) ? 1 : (pkt == K_EDS) ?
                  `AURORA_EDS_WORDS + 1 : `AURORA_ENC_WORDS)),
                  $sformatf("tlast is %b on beat %0d", tx_tlast_o, beat));
            beat++;
            if (tx_tlast_o) begin
                if (pkt == K_EDS)
                    check(eds_pack_cnt_o == 32'(done[K_EDS] + 1), "EDS packet counter is off");
                if (pkt == K_ENC)
                    check(encode_pack_cnt_o == 32'(done[K_ENC] + 1), "encode counter is off");
                if (pkt != 0)
                    done[pkt]++;
                beat = 0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic await_progress(input int kind, input int target, input int limit,
                                  input string what);
        int n;
        n = 0;
        while (done[kind] < target && n < limit) begin
            @(negedge USER_CLK);
            n++;
        end
        if (done[kind] < target) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_sequence();
        // EDS session requested while the channel is down, then a short glitch
        @(posedge USER_CLK);
        eds_frame_en_i <= 1'b1;
        repeat (30) @(posedge USER_CLK);
        CHANNEL_UP <= 1'b1;
        repeat (8) @(posedge USER_CLK);
        CHANNEL_UP <= 1'b0;
        repeat (2) @(posedge USER_CLK);
        CHANNEL_UP <= 1'b1;
        await_progress(K_EDS, 3, 6000, "three EDS data packets");
        if (timed_out)
            return;
        eds_closing = 1'b1;
        @(posedge USER_CLK);
        eds_frame_en_i <= 1'b0;
        pcie_eds_end_i <= 1'b1;
        @(posedge USER_CLK);
        pcie_eds_end_i <= 1'b0;
        await_progress(K_CTRL, 2, 3000, "the EDS end packet");
        if (timed_out)
            return;
        enc_phase = 1'b1;
        @(posedge USER_CLK);
        pmt_start_en_i <= 1'b1;
        await_progress(K_ENC_HDR, 2, 4000, "the second encode packet");
        if (timed_out)
            return;
        // End the encode session in the middle of its second packet
        repeat (20) @(negedge USER_CLK);
        enc_stop = 1'b1;
        @(posedge USER_CLK);
        pcie_pmt_end_i <= 1'b1;
        pmt_start_en_i <= 1'b0;
        @(posedge USER_CLK);
        pcie_pmt_end_i <= 1'b0;
        await_progress(K_ENC, 2, 3000, "the last encode packet");
        if (timed_out)
            return;
        repeat (300) @(negedge USER_CLK);
        check(done[K_CTRL] == 2 && done[K_ENC_HDR] == 2, "wrong number of packets");
        check(eds_pack_cnt_o == 32'(done[K_EDS]), "EDS counter differs from packets seen");
        check(encode_pack_cnt_o == 32'd2, "encode counter is not 2");
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    initial begin
        repeat (2) @(posedge USER_CLK);
        RESET <= 1'b0;
        @(negedge USER_CLK);
        check(!tx_tvalid_o && !tx_tlast_o, "stream not idle after reset");
        check(eds_pack_cnt_o == '0 && encode_pack_cnt_o == '0, "counters not cleared");
        check(!eds_rd_o && !eds_encode_rd_o && !encode_rd_o, "read strobe after reset");
        run_sequence();
        finish_run();
    end

endmodule

/* src/aurora_tx_framer.sv */
module aurora_tx_framer (
    input  logic                      USER_CLK,
    input  logic                      RESET,
    input  logic                      CHANNEL_UP,
    // Sessions
    input  logic                      eds_frame_en_i,
    input  logic                      pmt_start_en_i,
    input  logic                      pcie_eds_end_i,
    input  logic                      pcie_pmt_end_i,
    // EDS FIFO and encoder FIFO
    input  aurora_tx_pkg::word_t      eds_data_i,
    input  aurora_tx_pkg::eds_count_t eds_count_i,
    output logic                      eds_rd_o,
    input  logic                      eds_encode_empty_i,
    input  aurora_tx_pkg::half_t      encoder_w_i,
    input  aurora_tx_pkg::half_t      encoder_x_i,
    output logic                      eds_encode_rd_o,
    // Encode FIFO
    input  aurora_tx_pkg::word_t      encode_data_i,
    input  aurora_tx_pkg::enc_count_t enc_count_i,
    output logic                      encode_rd_o,
    // User channel stream
    output logic                      tx_tvalid_o,
    output aurora_tx_pkg::word_t      tx_tdata_o,
    output logic                      tx_tlast_o,
    input  logic                      tx_tready_i,
    // Progress
    output aurora_tx_pkg::pack_cnt_t  eds_pack_cnt_o,
    output aurora_tx_pkg::pack_cnt_t  encode_pack_cnt_o
);

    aurora_tx_pkg::link_evt_t evt;
    aurora_tx_pkg::pkt_cmd_t  cmd;
    logic                     cmd_valid;
    logic                     pkt_done;

    link_qualifier link_qualifier_i (
        .USER_CLK       (USER_CLK),
        .RESET          (RESET),
        .channel_up_i   (CHANNEL_UP),
        .eds_frame_en_i (eds_frame_en_i),
        .pmt_start_en_i (pmt_start_en_i),
        .evt_o          (evt)
    );

    session_scheduler session_scheduler_i (
        .USER_CLK           (USER_CLK),
        .RESET              (RESET),
        .evt_i              (evt),
        .pcie_eds_end_i     (pcie_eds_end_i),
        .pcie_pmt_end_i     (pcie_pmt_end_i),
        .eds_encode_empty_i (eds_encode_empty_i),
        .eds_count_i        (eds_count_i),
        .enc_count_i        (enc_count_i),
        .pkt_done_i         (pkt_done),
        .cmd_valid_o        (cmd_valid),
        .cmd_o              (cmd),
        .eds_pack_cnt_o     (eds_pack_cnt_o),
        .encode_pack_cnt_o  (encode_pack_cnt_o)
    );

    packet_streamer packet_streamer_i (
        .USER_CLK        (USER_CLK),
        .RESET           (RESET),
        .link_ready_i    (evt.link_ready),
        .cmd_valid_i     (cmd_valid),
        .cmd_i           (cmd),
        .eds_data_i      (eds_data_i),
        .encode_data_i   (encode_data_i),
        .encoder_w_i     (encoder_w_i),
        .encoder_x_i     (encoder_x_i),
        .tx_tready_i     (tx_tready_i),
        .eds_rd_o        (eds_rd_o),
        .eds_encode_rd_o (eds_encode_rd_o),
        .encode_rd_o     (encode_rd_o),
        .pkt_done_o      (pkt_done),
        .tx_tvalid_o     (tx_tvalid_o),
        .tx_tlast_o      (tx_tlast_o),
        .tx_tdata_o      (tx_tdata_o)
    );

endmodule

/* src/packet_streamer.sv */
`include "aurora_tx_defines.svh"

module packet_streamer (
    input  logic                    USER_CLK,
    input  logic                    RESET,
    input  logic                    link_ready_i,
    input  logic                    cmd_valid_i,
    input  aurora_tx_pkg::pkt_cmd_t cmd_i,
    input  aurora_tx_pkg::word_t    eds_data_i,
    input  aurora_tx_pkg::word_t    encode_data_i,
    input  aurora_tx_pkg::half_t    encoder_w_i,
    input  aurora_tx_pkg::half_t    encoder_x_i,
    input  logic                    tx_tready_i,
    output logic                    eds_rd_o,
    output logic                    eds_encode_rd_o,
    output logic                    encode_rd_o,
    output logic                    pkt_done_o,
    output logic                    tx_tvalid_o,
    output logic                    tx_tlast_o,
    output aurora_tx_pkg::word_t    tx_tdata_o
);

    localparam int         BEAT_W   = $clog2(`AURORA_ENC_WORDS + 2);
    localparam logic [BEAT_W-1:0] EDS_LAST = `AURORA_EDS_WORDS + 1;
    localparam logic [BEAT_W-1:0] ENC_LAST = `AURORA_ENC_WORDS;

    aurora_tx_pkg::pkt_kind_t kind_q;
    aurora_tx_pkg::pkt_kind_t cur_kind;
    aurora_tx_pkg::word_t     beat_word;
    logic [BEAT_W-1:0]        beat_cnt;
    logic [BEAT_W-1:0]        cur_idx;
    logic                     busy;
    logic                     load;
    logic                     beat_last;
    logic                     pop_eds;
    logic                     pop_enc_w;
    logic                     pop_enc;

    //////////////////////////////////////////////////
    // Beat selection
    //////////////////////////////////////////////////

    // A new command starts at beat 0 straight away
    assign cur_kind = cmd_valid_i ? cmd_i.kind : kind_q;
    assign cur_idx  = cmd_valid_i ? '0 : beat_cnt;
    assign load     = link_ready_i &
                      (cmd_valid_i | (busy & (~tx_tvalid_o | tx_tready_i)));

    always_comb begin
        beat_word = '0;
        beat_last = 1'b0;
        pop_eds   = 1'b0;
        pop_enc_w = 1'b0;
        pop_enc   = 1'b0;
        case (cur_kind)
            aurora_tx_pkg::PKT_EDS_START,
            aurora_tx_pkg::PKT_EDS_END: begin
                if (cur_idx == '0) begin
                    beat_word = `AURORA_HDR_CTRL;
                end else begin
                    beat_word = (cur_kind == aurora_tx_pkg::PKT_EDS_START) ?
                                `AURORA_CODE_EDS_START : `AURORA_CODE_EDS_END;
                    beat_last = 1'b1;
                end
            end
            aurora_tx_pkg::PKT_EDS_DATA: begin
                if (cur_idx == '0) begin
                    beat_word = `AURORA_HDR_EDS;
                end else if (cur_idx == BEAT_W'(1)) begin
                    // Encoder word, w in the upper half
                    beat_word = {encoder_w_i, encoder_x_i};
                    pop_enc_w = 1'b1;
                end else begin
                    beat_word = eds_data_i;
                    pop_eds   = 1'b1;
                    beat_last = (cur_idx == EDS_LAST);
                end
            end
            default: begin
                if (cur_idx == '0) begin
                    beat_word = `AURORA_HDR_ENC;
                end else begin
                    beat_word = encode_data_i;
                    pop_enc   = 1'b1;
                    beat_last = (cur_idx == ENC_LAST);
                end
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge USER_CLK) begin
        if (RESET || !link_ready_i) begin
            busy        <= 1'b0;
            tx_tvalid_o <= 1'b0;
            tx_tlast_o  <= 1'b0;
        end else if (load) begin
            busy        <= ~beat_last;
            tx_tvalid_o <= 1'b1;
            tx_tlast_o  <= beat_last;
        end else if (tx_tvalid_o && tx_tready_i) begin
            tx_tvalid_o <= 1'b0;
            tx_tlast_o  <= 1'b0;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (load) begin
            tx_tdata_o <= beat_word;
            kind_q     <= cur_kind;
            beat_cnt   <= cur_idx + BEAT_W'(1);
        end
    end

    // FIFO pops coincide with the load of their word
    assign eds_rd_o        = load & pop_eds;
    assign eds_encode_rd_o = load & pop_enc_w;
    assign encode_rd_o     = load & pop_enc;
    assign pkt_done_o      = tx_tvalid_o & tx_tready_i & tx_tlast_o;

endmodule

/* src/session_scheduler.sv */
`include "aurora_tx_defines.svh"

module session_scheduler (
    input  logic                      USER_CLK,
    input  logic                      RESET,
    input  aurora_tx_pkg::link_evt_t  evt_i,
    input  logic                      pcie_eds_end_i,
    input  logic                      pcie_pmt_end_i,
    input  logic                      eds_encode_empty_i,
    input  aurora_tx_pkg::eds_count_t eds_count_i,
    input  aurora_tx_pkg::enc_count_t enc_count_i,
    input  logic                      pkt_done_i,
    output logic                      cmd_valid_o,
    output aurora_tx_pkg::pkt_cmd_t   cmd_o,
    output aurora_tx_pkg::pack_cnt_t  eds_pack_cnt_o,
    output aurora_tx_pkg::pack_cnt_t  encode_pack_cnt_o
);

    localparam aurora_tx_pkg::eds_count_t EDS_THRESH  = `AURORA_EDS_THRESH;
    localparam aurora_tx_pkg::enc_count_t ENC_THRESH  = `AURORA_ENC_THRESH;
    localparam logic [7:0]                SETTLE_LAST = `AURORA_PCIE_SETTLE - 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_EDS_START,
        S_PCIE_SETTLE,
        S_EDS_WAIT,
        S_EDS_SEND,
        S_ENC_WAIT,
        S_ENC_SEND
    } state_t;

    state_t     state;
    logic [7:0] settle_cnt;
    logic       eds_end_flag;
    logic       pmt_end_flag;
    logic       last_pkg;
    logic       eds_due;
    logic       enc_due;
    logic       abort;

    function automatic aurora_tx_pkg::pack_cnt_t sat_inc(input aurora_tx_pkg::pack_cnt_t c);
        return c[31] ? c : c + 32'd1;
    endfunction

    assign eds_due = (eds_count_i >= EDS_THRESH) && !eds_encode_empty_i;
    assign enc_due = (enc_count_i >= ENC_THRESH);
    // Channel loss or a fresh session start restarts everything
    assign abort   = !evt_i.link_ready || evt_i.eds_rise || evt_i.pmt_rise;

    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            state             <= S_IDLE;
            cmd_valid_o       <= 1'b0;
            cmd_o.kind        <= aurora_tx_pkg::PKT_EDS_START;
            settle_cnt        <= '0;
            eds_end_flag      <= 1'b0;
            pmt_end_flag      <= 1'b0;
            last_pkg          <= 1'b0;
            eds_pack_cnt_o    <= '0;
            encode_pack_cnt_o <= '0;
        end else begin
            cmd_valid_o <= 1'b0;

            // PCIe end requests are held until the session closes
            if (state == S_IDLE) begin
                eds_end_flag <= 1'b0;
                pmt_end_flag <= 1'b0;
                last_pkg     <= 1'b0;
            end else begin
                if (pcie_eds_end_i)
                    eds_end_flag <= 1'b1;
                if (pcie_pmt_end_i)
                    pmt_end_flag <= 1'b1;
            end

            if (state == S_PCIE_SETTLE)
                settle_cnt <= settle_cnt + 8'd1;
            else
                settle_cnt <= '0;

            if (abort) begin
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (evt_i.eds_level) begin
                            state          <= S_EDS_START;
                            cmd_valid_o    <= 1'b1;
                            cmd_o.kind     <= aurora_tx_pkg::PKT_EDS_START;
                            eds_pack_cnt_o <= '0;
                        end else if (evt_i.pmt_level) begin
                            state             <= S_ENC_WAIT;
                            encode_pack_cnt_o <= '0;
                        end
                    end
                    S_EDS_START: begin
                        if (pkt_done_i)
                            state <= S_PCIE_SETTLE;
                    end
                    S_PCIE_SETTLE: begin
                        if (settle_cnt == SETTLE_LAST)
                            state <= S_EDS_WAIT;
                    end
                    S_EDS_WAIT: begin
                        if (!last_pkg && !evt_i.eds_level) begin
                            // Frame enable dropped, close the session
                            state       <= S_EDS_SEND;
                            cmd_valid_o <= 1'b1;
                            cmd_o.kind  <= aurora_tx_pkg::PKT_EDS_END;
                            last_pkg    <= 1'b1;
                        end else if (last_pkg && eds_end_flag) begin
                            state <= S_IDLE;
                        end else if (eds_due) begin
                            state          <= S_EDS_SEND;
                            cmd_valid_o    <= 1'b1;
                            cmd_o.kind     <= aurora_tx_pkg::PKT_EDS_DATA;
                            eds_pack_cnt_o <= sat_inc(eds_pack_cnt_o);
                        end else if (eds_end_flag) begin
                            state <= S_IDLE;
                        end
                    end
                    S_EDS_SEND: begin
                        if (pkt_done_i)
                            state <= S_EDS_WAIT;
                    end
                    S_ENC_WAIT: begin
                        if (pmt_end_flag) begin
                            state <= S_IDLE;
                        end else if (enc_due) begin
                            state             <= S_ENC_SEND;
                            cmd_valid_o       <= 1'b1;
                            cmd_o.kind        <= aurora_tx_pkg::PKT_ENC_DATA;
                            encode_pack_cnt_o <= sat_inc(encode_pack_cnt_o);
                        end
                    end
                    S_ENC_SEND: begin
                        if (pkt_done_i)
                            state <= S_ENC_WAIT;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

/* src/link_qualifier.sv */
`include "aurora_tx_defines.svh"

module link_qualifier (
    input  logic                     USER_CLK,
    input  logic                     RESET,
    input  logic                     channel_up_i,
    input  logic                     eds_frame_en_i,
    input  logic                     pmt_start_en_i,
    output aurora_tx_pkg::link_evt_t evt_o
);

    localparam logic [4:0] UP_READY = `AURORA_LINK_DEBOUNCE;

    logic [4:0] up_cnt;
    logic [1:0] eds_sync;
    logic [1:0] pmt_sync;
    logic       eds_rise_q;
    logic       pmt_rise_q;

    always_ff @(posedge USER_CLK) begin
        if (RESET) begin
            up_cnt     <= '0;
            eds_sync   <= '0;
            pmt_sync   <= '0;
            eds_rise_q <= 1'b0;
            pmt_rise_q <= 1'b0;
        end else begin
            // Any drop of the channel restarts the debounce
            if (!channel_up_i)
                up_cnt <= '0;
            else if (up_cnt != UP_READY)
                up_cnt <= up_cnt + 5'd1;
            eds_sync   <= {eds_sync[0], eds_frame_en_i};
            pmt_sync   <= {pmt_sync[0], pmt_start_en_i};
            // Edge strobe lines up with the synchronized level
            eds_rise_q <= eds_sync[0] & ~eds_sync[1];
            pmt_rise_q <= pmt_sync[0] & ~pmt_sync[1];
        end
    end

    assign evt_o.link_ready = (up_cnt == UP_READY);
    assign evt_o.eds_level  = eds_sync[1];
    assign evt_o.pmt_level  = pmt_sync[1];
    assign evt_o.eds_rise   = eds_rise_q;
    assign evt_o.pmt_rise   = pmt_rise_q;

endmodule

/* src/aurora_tx_pkg.sv */
`include "aurora_tx_defines.svh"

package aurora_tx_pkg;

    // Stream and FIFO words
    typedef logic [`AURORA_WORD_W-1:0]    word_t;
    typedef logic [`AURORA_HALF_W-1:0]    half_t;

    // FIFO fill counts
    typedef logic [`AURORA_EDS_CNT_W-1:0] eds_count_t;
    typedef logic [`AURORA_ENC_CNT_W-1:0] enc_count_t;

    // Saturating packet counter
    typedef logic [31:0]                  pack_cnt_t;

    typedef enum logic [1:0] {
        PKT_EDS_START,
        PKT_EDS_END,
        PKT_EDS_DATA,
        PKT_ENC_DATA
    } pkt_kind_t;

    // Qualified channel and session enables
    typedef struct packed {
        logic link_ready;
        logic eds_level;
        logic pmt_level;
        logic eds_rise;
        logic pmt_rise;
    } link_evt_t;

    // One packet request to the output stage
    typedef struct packed {
        pkt_kind_t kind;
    } pkt_cmd_t;

endpackage

/* src/aurora_tx_defines.svh */
`ifndef AURORA_TX_DEFINES_SVH
`define AURORA_TX_DEFINES_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////
`define AURORA_WORD_W           64
`define AURORA_HALF_W           32
`define AURORA_EDS_CNT_W        14
`define AURORA_ENC_CNT_W        12

//////////////////////////////////////////////////
// Packet lengths and thresholds
//////////////////////////////////////////////////
`define AURORA_EDS_WORDS        512
`define AURORA_ENC_WORDS        1024
`define AURORA_EDS_THRESH       511
`define AURORA_ENC_THRESH       1023

// Cycles of wait so the PCIe card can clear its buffers
`define AURORA_PCIE_SETTLE      200
`define AURORA_LINK_DEBOUNCE    16

//////////////////////////////////////////////////
// Header and control codes
//////////////////////////////////////////////////
`define AURORA_HDR_CTRL         64'h0000_0000_55aa_0001
`define AURORA_HDR_EDS          64'h0000_0000_55aa_0002
`define AURORA_HDR_ENC          64'h0000_0000_55aa_0003
`define AURORA_CODE_EDS_START   64'h0000_0000_0000_0001
`define AURORA_CODE_EDS_END     64'h0000_0000_0000_0000

`endif
